// File: hdl/cce_link_pkg.sv
package cce_link_pkg;

  // ####################
  // widths

  localparam int block_width_c     = 512;
  localparam int link_data_width_c = 32;
  localparam int num_flits_c       = block_width_c / link_data_width_c;
  localparam int flit_idx_width_c  = 4;

  localparam int paddr_width_c     = 32;
  localparam int link_addr_width_c = 16; // word address on the mesh.
  localparam int x_cord_width_c    = 4;
  localparam int y_cord_width_c    = 4;
  localparam int mask_width_c      = link_data_width_c / 8;

  localparam int tag_width_c       = 8;
  localparam int msg_type_width_c  = 3;

  // ####################
  // network packet op

  typedef enum logic [1:0] {
    e_link_op_remote_load  = 2'b00,
    e_link_op_remote_store = 2'b01, // the only op this bridge issues.
    e_link_op_remote_amo   = 2'b10,
    e_link_op_config       = 2'b11
  } link_op_e;

  // ####################
  // payload structs

  typedef struct packed {
    logic [msg_type_width_c-1:0] msg_type;
    logic [paddr_width_c-1:0]    addr;
    logic [tag_width_c-1:0]      tag;
    logic [block_width_c-1:0]    data; // word k sits at bit 32k.
  } wb_cmd_s;

  typedef struct packed {
    logic [msg_type_width_c-1:0] msg_type;
    logic [paddr_width_c-1:0]    addr;
    logic [tag_width_c-1:0]      tag;
  } mem_resp_s;

  typedef struct packed {
    logic [link_addr_width_c-1:0] addr;
    link_op_e                     op;
    logic [mask_width_c-1:0]      op_ex; // byte mask for a store.
    logic [link_data_width_c-1:0] payload;
    logic [x_cord_width_c-1:0]    src_x;
    logic [y_cord_width_c-1:0]    src_y;
    logic [x_cord_width_c-1:0]    x;
    logic [y_cord_width_c-1:0]    y;
  } link_pkt_s;

endpackage

// File: hdl/bridge_fifo.sv
module bridge_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  els_p     = 2
) (
  input  logic     clk_i,
  input  logic     reset_i,

  input  payload_t data_i,
  input  logic     v_i,
  output logic     ready_o,

  output payload_t data_o,
  output logic     v_o,
  input  logic     yumi_i
);

  localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_width_lp = $clog2(els_p + 1);

  payload_t mem_r [els_p];

  logic [ptr_width_lp-1:0] wptr_r, rptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic                    push, pop;

  // ####################
  // flags

  assign ready_o = (count_r != cnt_width_lp'(els_p)); // room for one more.
  assign v_o     = (count_r != '0);

  assign push = v_i & ready_o;
  assign pop  = yumi_i & v_o;

  assign data_o = mem_r[rptr_r];

  // ####################
  // storage and pointers

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end else begin
      if (push) begin
        wptr_r <= (wptr_r == ptr_width_lp'(els_p - 1)) ? '0 : wptr_r + 1'b1;
      end
      if (pop) begin
        rptr_r <= (rptr_r == ptr_width_lp'(els_p - 1)) ? '0 : rptr_r + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r; // both or neither leave the count alone.
      endcase
    end
  end

endmodule

// File: hdl/wb_flit_sequencer.sv
module wb_flit_sequencer (
  input  logic                                      clk_i,
  input  logic                                      reset_i,

  // coherence side, command in.
  input  cce_link_pkg::wb_cmd_s                     cmd_i,
  input  logic                                      cmd_v_i,
  output logic                                      cmd_yumi_o,

  // network side.
  output cce_link_pkg::link_pkt_s                   tx_pkt_o,
  output logic                                      tx_pkt_v_o,
  input  logic                                      tx_pkt_yumi_i,

  // coherence side, response out.
  output cce_link_pkg::mem_resp_s                   resp_o,
  output logic                                      resp_v_o,
  input  logic                                      resp_ready_i,

  input  logic [cce_link_pkg::x_cord_width_c-1:0]   my_x_i,
  input  logic [cce_link_pkg::y_cord_width_c-1:0]   my_y_i
);

  // byte offset inside one word, then the flit index above it.
  localparam int byte_off_lp  = $clog2(cce_link_pkg::link_data_width_c / 8);
  localparam int addr_lsb_lp  = byte_off_lp + cce_link_pkg::flit_idx_width_c;
  localparam int addr_bits_lp =
    cce_link_pkg::link_addr_width_c - 1 - cce_link_pkg::flit_idx_width_c;
  localparam int x_lsb_lp     = addr_lsb_lp + addr_bits_lp;
  localparam int cnt_width_lp = cce_link_pkg::flit_idx_width_c + 1;

  typedef enum logic [1:0] {
    e_idle    = 2'b00,
    e_send    = 2'b01,
    e_respond = 2'b10
  } seq_state_e;

  seq_state_e state_r, state_n;

  cce_link_pkg::wb_cmd_s cmd_r;

  logic [cnt_width_lp-1:0]                     flit_cnt_r, flit_cnt_n;
  logic [cce_link_pkg::flit_idx_width_c-1:0]   flit_idx;
  logic                                        capture;
  logic                                        flit_done;

  // ####################
  // control

  assign capture   = cmd_yumi_o;
  assign flit_done = tx_pkt_v_o & tx_pkt_yumi_i; // one packet leaves.

  always_comb begin
    state_n    = state_r;
    flit_cnt_n = flit_cnt_r;
    cmd_yumi_o = 1'b0;
    tx_pkt_v_o = 1'b0;
    resp_v_o   = 1'b0;

    case (state_r)
      e_idle: begin
        cmd_yumi_o = cmd_v_i; // take the head as soon as it shows up.
        if (cmd_v_i) begin
          flit_cnt_n = '0;
          state_n    = e_send;
        end
      end

      e_send: begin
        tx_pkt_v_o = 1'b1;
        if (flit_done) begin
          flit_cnt_n = flit_cnt_r + 1'b1;
          if (flit_cnt_n == cnt_width_lp'(cce_link_pkg::num_flits_c)) begin
            state_n = e_respond;
          end
        end
      end

      e_respond: begin
        resp_v_o = resp_ready_i; // push only when the response FIFO has room.
        if (resp_ready_i) begin
          state_n = e_idle;
        end
      end

      default: begin
        state_n = e_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= e_idle;
      flit_cnt_r <= '0;
    end else begin
      state_r    <= state_n;
      flit_cnt_r <= flit_cnt_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      cmd_r <= cmd_i;
    end
  end

  // ####################
  // packet formation

  assign flit_idx = flit_cnt_r[cce_link_pkg::flit_idx_width_c-1:0];

  always_comb begin
    tx_pkt_o.addr    = {1'b0, cmd_r.addr[addr_lsb_lp+:addr_bits_lp], flit_idx};
    tx_pkt_o.op      = cce_link_pkg::e_link_op_remote_store;
    tx_pkt_o.op_ex   = '1; // whole words only.
    tx_pkt_o.payload =
      cmd_r.data[flit_idx*cce_link_pkg::link_data_width_c+:cce_link_pkg::link_data_width_c];
    tx_pkt_o.src_x   = my_x_i;
    tx_pkt_o.src_y   = my_y_i;
    tx_pkt_o.x       = cmd_r.addr[x_lsb_lp+:cce_link_pkg::x_cord_width_c];
    tx_pkt_o.y       = my_y_i;
  end

  // ####################
  // response

  always_comb begin
    resp_o.msg_type = cmd_r.msg_type;
    resp_o.addr     = cmd_r.addr;
    resp_o.tag      = cmd_r.tag;
  end

endmodule

// File: hdl/cce_link_bridge.sv
module cce_link_bridge #(
  parameter int cmd_fifo_els_p  = 2,
  parameter int resp_fifo_els_p = 2
) (
  input  logic                                      clk_i,
  input  logic                                      reset_i,

  // coherence side.
  input  cce_link_pkg::wb_cmd_s                     mem_cmd_i,
  input  logic                                      mem_cmd_v_i,
  output logic                                      mem_cmd_yumi_o,

  output cce_link_pkg::mem_resp_s                   mem_resp_o,
  output logic                                      mem_resp_v_o,
  input  logic                                      mem_resp_ready_i,

  // mesh side.
  output cce_link_pkg::link_pkt_s                   tx_pkt_o,
  output logic                                      tx_pkt_v_o,
  input  logic                                      tx_pkt_yumi_i,

  input  logic [cce_link_pkg::x_cord_width_c-1:0]   my_x_i,
  input  logic [cce_link_pkg::y_cord_width_c-1:0]   my_y_i
);

  cce_link_pkg::wb_cmd_s   cmd_head;
  cce_link_pkg::mem_resp_s seq_resp;

  logic cmd_fifo_ready;
  logic cmd_head_v, cmd_head_yumi;
  logic seq_resp_v, resp_fifo_ready;

  // a command is taken in the same cycle it is offered, if there is room.
  assign mem_cmd_yumi_o = mem_cmd_v_i & cmd_fifo_ready;

  bridge_fifo #(
    .payload_t (cce_link_pkg::wb_cmd_s),
    .els_p     (cmd_fifo_els_p)
  ) cmd_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (mem_cmd_i),
    .v_i     (mem_cmd_v_i),
    .ready_o (cmd_fifo_ready),
    .data_o  (cmd_head),
    .v_o     (cmd_head_v),
    .yumi_i  (cmd_head_yumi)
  );

  wb_flit_sequencer seq (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cmd_i         (cmd_head),
    .cmd_v_i       (cmd_head_v),
    .cmd_yumi_o    (cmd_head_yumi),
    .tx_pkt_o      (tx_pkt_o),
    .tx_pkt_v_o    (tx_pkt_v_o),
    .tx_pkt_yumi_i (tx_pkt_yumi_i),
    .resp_o        (seq_resp),
    .resp_v_o      (seq_resp_v),
    .resp_ready_i  (resp_fifo_ready),
    .my_x_i        (my_x_i),
    .my_y_i        (my_y_i)
  );

  bridge_fifo #(
    .payload_t (cce_link_pkg::mem_resp_s),
    .els_p     (resp_fifo_els_p)
  ) resp_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (seq_resp),
    .v_i     (seq_resp_v),
    .ready_o (resp_fifo_ready),
    .data_o  (mem_resp_o),
    .v_o     (mem_resp_v_o),
    .yumi_i  (mem_resp_ready_i & mem_resp_v_o) // valid/ready transfer.
  );

endmodule

// File: dv/cce_link_bridge_tb.sv
module cce_link_bridge_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int period_c     = 8;
  localparam int num_cmds_c   = 40;
  localparam int timeout_ns_c = num_cmds_c * 16 * 8 * period_c + 5000;

  logic clk_i, reset_i, stall;
  cce_link_pkg::wb_cmd_s   mem_cmd_i;
  logic                    mem_cmd_v_i, mem_cmd_yumi_o;
  cce_link_pkg::mem_resp_s mem_resp_o;
  logic                    mem_resp_v_o, mem_resp_ready_i;
  cce_link_pkg::link_pkt_s tx_pkt_o;
  logic                    tx_pkt_v_o, tx_pkt_yumi_i;
  logic [3:0]              my_x_i, my_y_i;

  // scoreboard state, all of it seen by the assertions one cycle late.
  cce_link_pkg::wb_cmd_s   cmd_q[$], done_q[$];
  cce_link_pkg::wb_cmd_s   head_cmd, done_cmd;
  cce_link_pkg::link_pkt_s exp_pkt, prev_pkt;
  cce_link_pkg::mem_resp_s exp_resp, prev_resp;
  logic                    head_v, done_v;
  logic [3:0]              flit_idx;
  int                      yumi_cnt, resp_cnt;

  cce_link_bridge #(.cmd_fifo_els_p(2), .resp_fifo_els_p(2)) cce_link_bridge_inst (.*);

  // ####################
  // helpers

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic value_error(input string sig, input logic [127:0] expected,
                             input logic [127:0] actual);
    stop_on_error($sformatf("Error at %0t: %s expected %h, got %h", $time, sig,
                            expected, actual));
  endtask

  function automatic cce_link_pkg::link_pkt_s format_pkt(input cce_link_pkg::wb_cmd_s cmd,
      input logic [3:0] idx, input logic [3:0] x, input logic [3:0] y);
    cce_link_pkg::link_pkt_s pkt;
    pkt.addr    = {1'b0, cmd.addr[16:6], idx}; // word address of flit idx.
    pkt.op      = cce_link_pkg::e_link_op_remote_store;
    pkt.op_ex   = 4'hf;
    pkt.payload = cmd.data[32*idx +: 32];
    pkt.src_x   = x;
    pkt.src_y   = y;
    pkt.x       = cmd.addr[20:17];
    pkt.y       = y;
    return pkt;
  endfunction

  function automatic cce_link_pkg::mem_resp_s echo_resp(input cce_link_pkg::wb_cmd_s cmd);
    cce_link_pkg::mem_resp_s resp;
    resp.msg_type = cmd.msg_type;
    resp.addr     = cmd.addr;
    resp.tag      = cmd.tag;
    return resp;
  endfunction

  function automatic cce_link_pkg::wb_cmd_s rand_cmd();
    cce_link_pkg::wb_cmd_s cmd;
    cmd.msg_type = $urandom;
    cmd.addr     = $urandom;
    cmd.tag      = $urandom;
    for (int k = 0; k < 16; k++) begin
      cmd.data[32*k +: 32] = $urandom;
    end
    return cmd;
  endfunction

  task automatic send_cmd(input cce_link_pkg::wb_cmd_s cmd);
    mem_cmd_i   = cmd;
    mem_cmd_v_i = 1'b1;
    @(posedge clk_i);
    while (!mem_cmd_yumi_o) @(posedge clk_i);
    #1;
    mem_cmd_v_i = 1'b0;
  endtask

  assign exp_pkt  = format_pkt(head_cmd, flit_idx, my_x_i, my_y_i);
  assign exp_resp = echo_resp(done_cmd);

  // ####################
  // clock, stimulus, watchdog

  initial begin
    clk_i = 1'b0;
    forever #(period_c / 2) clk_i = ~clk_i;
  end

  initial begin : sink_drive
    tx_pkt_yumi_i    = 1'b0;
    mem_resp_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      tx_pkt_yumi_i    = !reset_i && tx_pkt_v_o && ($urandom_range(9) < 6);
      mem_resp_ready_i = !reset_i && !stall && ($urandom_range(3) != 0);
    end
  end

  initial begin
    #(timeout_ns_c);
    stop_on_error($sformatf("Timeout: the run did not finish within %0d ns.", timeout_ns_c));
  end

  initial begin : main_flow
    int unsigned gap;
    void'($urandom(32'h1c8e_9cbb));
    reset_i     = 1'b1;
    stall       = 1'b0;
    mem_cmd_i   = '0;
    mem_cmd_v_i = 1'b0;
    my_x_i      = $urandom;
    my_y_i      = $urandom;
    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    fork
      for (int i = 0; i < num_cmds_c; i++) begin
        send_cmd(rand_cmd());
        gap = $urandom_range(3);
        if (gap > 0) begin
          repeat (gap) @(posedge clk_i);
          #1;
        end
      end
      begin
        while (yumi_cnt < 12) @(posedge clk_i);
        stall = 1'b1; // hold responses until every stage backs up.
        repeat (100) @(posedge clk_i);
        stall = 1'b0;
      end
    join
    while (resp_cnt < num_cmds_c) @(posedge clk_i);
    repeat (20) @(posedge clk_i);
    if (resp_cnt == yumi_cnt && yumi_cnt == num_cmds_c) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      value_error("response count", yumi_cnt, resp_cnt);
    end
  end

  // ####################
  // scoreboard

  always @(posedge clk_i) begin
    if (reset_i) begin
      cmd_q.delete();
      done_q.delete();
      head_v   <= 1'b0;
      done_v   <= 1'b0;
      flit_idx <= '0;
      yumi_cnt <= 0;
      resp_cnt <= 0;
    end else begin
      if (tx_pkt_v_o && tx_pkt_yumi_i) begin
        flit_idx <= flit_idx + 4'd1;
        if (flit_idx == 4'd15 && cmd_q.size() != 0) begin
          done_q.push_back(cmd_q.pop_front()); // last word gone, response now due.
        end
      end
      if (mem_resp_v_o && mem_resp_ready_i) begin
        resp_cnt <= resp_cnt + 1;
        if (done_q.size() != 0) void'(done_q.pop_front());
      end
      if (mem_cmd_v_i && mem_cmd_yumi_o) begin
        yumi_cnt <= yumi_cnt + 1;
        cmd_q.push_back(mem_cmd_i);
      end
      head_v <= (cmd_q.size() != 0);
      done_v <= (done_q.size() != 0);
      if (cmd_q.size() != 0) head_cmd <= cmd_q[0];
      if (done_q.size() != 0) done_cmd <= done_q[0];
    end
    prev_pkt  <= tx_pkt_o;
    prev_resp <= mem_resp_o;
  end

  // ####################
  // checks

  reset_pkt_v_a: assert property (@(posedge clk_i) reset_i |=> !tx_pkt_v_o)
    else value_error("tx_pkt_v_o", 0, $sampled(tx_pkt_v_o));
  reset_resp_v_a: assert property (@(posedge clk_i) reset_i |=> !mem_resp_v_o)
    else value_error("mem_resp_v_o", 0, $sampled(mem_resp_v_o));
  yumi_needs_v_a: assert property (@(posedge clk_i) mem_cmd_yumi_o |-> mem_cmd_v_i)
    else value_error("mem_cmd_yumi_o", 0, $sampled(mem_cmd_yumi_o));

  pkt_owner_a: assert property (@(posedge clk_i) disable iff (reset_i)
    tx_pkt_v_o && tx_pkt_yumi_i |-> head_v)
    else stop_on_error("A packet left while no accepted command was outstanding.");
  pkt_content_a: assert property (@(posedge clk_i) disable iff (reset_i)
    tx_pkt_v_o && tx_pkt_yumi_i |-> tx_pkt_o == exp_pkt)
    else value_error("tx_pkt_o", $sampled(exp_pkt), $sampled(tx_pkt_o));
  pkt_hold_v_a: assert property (@(posedge clk_i) disable iff (reset_i)
    tx_pkt_v_o && !tx_pkt_yumi_i |=> tx_pkt_v_o)
    else value_error("tx_pkt_v_o", 1, $sampled(tx_pkt_v_o));
  pkt_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    tx_pkt_v_o && !tx_pkt_yumi_i |=> tx_pkt_o == prev_pkt)
    else value_error("tx_pkt_o", $sampled(prev_pkt), $sampled(tx_pkt_o));

  resp_early_a: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_resp_v_o |-> done_v)
    else stop_on_error("A response was offered before the sixteenth flit of its command.");
  resp_content_a: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_resp_v_o && mem_resp_ready_i |-> mem_resp_o == exp_resp)
    else value_error("mem_resp_o", $sampled(exp_resp), $sampled(mem_resp_o));
  resp_hold_v_a: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_resp_v_o && !mem_resp_ready_i |=> mem_resp_v_o)
    else value_error("mem_resp_v_o", 1, $sampled(mem_resp_v_o));
  resp_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_resp_v_o && !mem_resp_ready_i |=> mem_resp_o == prev_resp)
    else value_error("mem_resp_o", $sampled(prev_resp), $sampled(mem_resp_o));

endmodule

// File: cce_link_bridge.f
hdl/cce_link_pkg.sv
hdl/bridge_fifo.sv
hdl/wb_flit_sequencer.sv
hdl/cce_link_bridge.sv
dv/cce_link_bridge_tb.sv

// File: Bender.yml
package:
  name: cce_link_bridge

sources:
  - target: any(simulation, synthesis, rtl)
    files:
      - hdl/cce_link_pkg.sv
      - hdl/bridge_fifo.sv
      - hdl/wb_flit_sequencer.sv
      - hdl/cce_link_bridge.sv

  - target: test
    files:
      - dv/cce_link_bridge_tb.sv
